// ==== files.f ====
+incdir+rtl
rtl/types_apb_pkg.sv
rtl/types_soc_pkg.sv
rtl/apb_bus1.sv
rtl/apb_gpio.sv
rtl/apb_timer.sv
rtl/apb_irqctrl.sv
rtl/apb_pnp.sv
rtl/periph_soc.sv
tb/periph_soc_assert.sv
tb/periph_soc_tb.sv

// ==== tb/periph_soc_tb.sv ====
// Testbench for periph_soc: drives the APB port, GPIO pins and checks every peripheral slot
`include "soc_cfg_macros.svh"
`timescale 1ns/1ps

module periph_soc_tb
    import types_apb_pkg::*;
    import types_soc_pkg::*;
;

    localparam int CLK_PERIOD = 100;
    localparam int CYCLES_PER_XFER = 3;        // Setup, access, idle
    localparam int MAX_WAITS = 8;
    localparam int XFER_BUDGET = 160;          // Upper bound on transfers of all tests
    localparam int WAIT_BUDGET = 400;          // Idle cycles spent outside transfers
    localparam longint WATCHDOG_NS =
        4 * (XFER_BUDGET * CYCLES_PER_XFER + WAIT_BUDGET) * CLK_PERIOD;

    logic clk = 1'b0;
    logic rst_n;
    apb_in_type apbi;
    apb_out_type apbo;
    logic [`SOC_GPIO_WIDTH-1:0] gpio_in;
    logic [`SOC_GPIO_WIDTH-1:0] gpio_out;
    logic [`SOC_GPIO_WIDTH-1:0] gpio_dir;
    logic mtip;
    logic meip;

    logic [31:0] rng_state = 32'h057d7a26;
    int cyc = 0;
    int last_cyc;                              // Cycle of the latest access sample
    int n_checks = 0;
    int n_errors = 0;
    int n_tests = 0;
    int n_xfers = 0;
    int chk_base = 0;
    int err_base = 0;

    periph_soc i_periph_soc (
        .i_sys_clk(clk),
        .i_rst_n(rst_n),
        .i_apbi(apbi),
        .o_apbo(apbo),
        .i_gpio(gpio_in),
        .o_gpio(gpio_out),
        .o_gpio_dir(gpio_dir),
        .o_mtip(mtip),
        .o_meip(meip)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] addr_of(input pslv_idx_e slot, input int unsigned offs);
        return {16'h0000, soc_map[slot].page, offs[9:0], 2'b00};
    endfunction

    // Reference models
    function automatic logic [`SOC_GPIO_WIDTH-1:0] exp_pins(input logic [31:0] v);
        return v[`SOC_GPIO_WIDTH-1:0];
    endfunction

    function automatic apb_data_t exp_gpio_reg(input logic [31:0] v);
        return apb_data_t'(exp_pins(v));       // Unused upper bits read zero
    endfunction

    function automatic apb_out_type exp_decode(input logic [31:0] addr);
        apb_out_type e;

        e = '0;
        e.pready = 1'b1;
        e.pslverr = !((addr[31:16] == 16'h0000) && (addr[15:12] < `SOC_PSLV_TOTAL));
        return e;
    endfunction

    function automatic apb_data_t exp_mtime_delta(input int n_xfers_between);
        return apb_data_t'(n_xfers_between * CYCLES_PER_XFER);
    endfunction

    // Level in a cycle follows the comparison of the cycle before
    function automatic logic exp_mtip(input logic [63:0] prev_mtime, input logic [63:0] cmp);
        return prev_mtime >= cmp;
    endfunction

    function automatic irq_id_t lowest_id(input logic [`SOC_IRQ_TOTAL-1:0] pend);
        irq_id_t id;

        id = '0;
        for (int i = 1; i < `SOC_IRQ_TOTAL; i++)
        begin
            if (pend[i] && (id == '0))
                id = irq_id_t'(i);
        end
        return id;
    endfunction

    function automatic apb_data_t exp_desc(input int slot);
        return {soc_map[slot].dev_id, 12'h000, soc_map[slot].page};
    endfunction

    task automatic check_data(input apb_data_t got, input apb_data_t exp, input string what);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("mismatch at %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_irq_id(input irq_id_t got, input irq_id_t exp, input string what);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("mismatch at %0t ns: %s gave id %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_gpio(input logic [`SOC_GPIO_WIDTH-1:0] got,
                              input logic [`SOC_GPIO_WIDTH-1:0] exp, input string what);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input apb_out_type got, input apb_out_type exp, input string what);
        n_checks++;
        if ((got.pready !== exp.pready) || (got.pslverr !== exp.pslverr))
        begin
            n_errors++;
            $display("mismatch at %0t ns: %s pready/pslverr %b%b, expected %b%b", $time, what,
                     got.pready, got.pslverr, exp.pready, exp.pslverr);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // One APB transfer; returns at the falling edge where psel drops
    task automatic apb_xfer(input logic wr, input logic [31:0] addr, input apb_data_t wdata,
                            output apb_out_type resp);
        int waits;

        @(negedge clk);
        apbi.psel = 1'b1;
        apbi.penable = 1'b0;
        apbi.pwrite = wr;
        apbi.paddr = addr;
        apbi.pwdata = wdata;
        @(negedge clk);
        apbi.penable = 1'b1;
        #10;
        waits = 0;
        while (!apbo.pready && (waits < MAX_WAITS))
        begin
            @(negedge clk);
            #10;
            waits++;
        end
        if (!apbo.pready)
        begin
            n_errors++;
            $display("no pready from the DUT for address %h at %0t ns", addr, $time);
        end
        else if (waits != 0)
        begin
            n_errors++;
            $display("transfer to %h needed %0d wait states instead of none", addr, waits);
        end
        resp = apbo;
        last_cyc = cyc;
        n_xfers++;
        @(negedge clk);
        apbi.psel = 1'b0;
        apbi.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input apb_data_t data,
                             output apb_out_type resp);
        apb_xfer(1'b1, addr, data, resp);
    endtask

    task automatic apb_read(input logic [31:0] addr, output apb_out_type resp);
        apb_xfer(1'b0, addr, '0, resp);
    endtask

    task automatic wait_meip(input logic level, input int limit);
        int n;

        n = 0;
        while ((meip !== level) && (n < limit))
        begin
            @(negedge clk);
            n++;
        end
        if (meip !== level)
        begin
            n_errors++;
            $display("o_meip did not go to %b within %0d cycles", level, limit);
        end
    endtask

    task automatic finish_test(input string name);
        n_tests++;
        $display("test %-8s done: %0d checks, %0d errors", name,
                 n_checks - chk_base, n_errors - err_base);
        chk_base = n_checks;
        err_base = n_errors;
    endtask

    task automatic test_gpio();
        apb_out_type r;
        logic [31:0] v_out;
        logic [31:0] v_dir;
        logic [31:0] v_in;

        for (int i = 0; i < 8; i++)
        begin
            v_out = rand32();
            v_dir = rand32();
            apb_write(addr_of(PSLV_GPIO, 1), v_out, r);
            apb_write(addr_of(PSLV_GPIO, 2), v_dir, r);
            apb_read(addr_of(PSLV_GPIO, 1), r);
            check_data(r.prdata, exp_gpio_reg(v_out), "gpio output register");
            apb_read(addr_of(PSLV_GPIO, 2), r);
            check_data(r.prdata, exp_gpio_reg(v_dir), "gpio direction register");
            check_gpio(gpio_out, exp_pins(v_out), "o_gpio");
            check_gpio(gpio_dir, exp_pins(v_dir), "o_gpio_dir");
            v_in = rand32();
            @(negedge clk);
            gpio_in = exp_pins(v_in);
            repeat (2) @(negedge clk);       // Two synchronizer stages
            apb_read(addr_of(PSLV_GPIO, 0), r);
            check_data(r.prdata, exp_gpio_reg(v_in), "gpio input register");
        end
    endtask

    task automatic test_decode();
        apb_out_type r;
        logic [31:0] v;
        logic [31:0] addr;
        logic [3:0] page;

        for (int i = 0; i < 12; i++)
        begin
            v = rand32();
            page = 4'(4 + (v[31:24] % 12));
            addr = {16'h0000, page, v[11:2], 2'b00};
            apb_write(addr, rand32(), r);
            check_resp(r, exp_decode(addr), "write to unmapped page");
            apb_read(addr, r);
            check_resp(r, exp_decode(addr), "read from unmapped page");
            check_data(r.prdata, '0, "unmapped read data");
        end
        for (int i = 0; i < 4; i++)
        begin
            v = rand32();
            addr = {v[31:16] | 16'h0001, v[15:2], 2'b00};   // Upper half never zero
            apb_read(addr, r);
            check_resp(r, exp_decode(addr), "read above 64 KiB");
            check_data(r.prdata, '0, "read data above 64 KiB");
        end
        for (int s = 0; s < `SOC_PSLV_TOTAL; s++)
        begin
            apb_read(addr_of(pslv_idx_e'(s), 0), r);
            check_resp(r, exp_decode(addr_of(pslv_idx_e'(s), 0)), "mapped slot read");
        end
    endtask

    task automatic test_timer();
        apb_out_type r;
        apb_data_t t1;
        apb_data_t m0;
        logic [63:0] cmp;
        int k;
        int c0;
        int j;
        logic [7:0] delta;

        apb_read(addr_of(PSLV_TIMER, 0), r);
        t1 = r.prdata;
        k = 1 + (rand32() % 3);
        for (int i = 0; i < k; i++)
            apb_read(addr_of(PSLV_TIMER, 2), r);
        apb_read(addr_of(PSLV_TIMER, 0), r);
        check_data(r.prdata - t1, exp_mtime_delta(k + 1), "mtime step between reads");

        apb_read(addr_of(PSLV_TIMER, 0), r);
        m0 = r.prdata;
        c0 = last_cyc;
        delta = rand32();
        cmp = {32'h0, m0 + 32'd16 + delta};   // Past the two compare writes
        apb_write(addr_of(PSLV_TIMER, 2), cmp[31:0], r);
        apb_write(addr_of(PSLV_TIMER, 3), cmp[63:32], r);
        j = cyc - c0;
        while (j <= 20 + delta)
        begin
            if (j >= 8)
                check_level(mtip, exp_mtip({32'h0, m0} + j - 1, cmp), "o_mtip");
            @(negedge clk);
            j = cyc - c0;
        end
        apb_write(addr_of(PSLV_TIMER, 3), 32'hFFFF_FFFF, r);
    endtask

    task automatic test_irq();
        apb_out_type r;
        logic [31:0] v;
        logic [`SOC_GPIO_WIDTH-1:0] mask;
        logic [`SOC_IRQ_TOTAL-1:0] pend;
        irq_id_t e;

        apb_write(addr_of(PSLV_GPIO, 3), '0, r);
        @(negedge clk);
        gpio_in = '0;
        repeat (4) @(negedge clk);
        v = rand32();
        mask = (v[`SOC_GPIO_WIDTH-1:0] | 1) & ~(1 << (`SOC_GPIO_WIDTH-1));  // Top pin disabled
        apb_write(addr_of(PSLV_IRQCTRL, 1), 32'h0000_3FFE, r);
        apb_write(addr_of(PSLV_GPIO, 3), mask, r);
        check_level(meip, 1'b0, "o_meip before edges");
        gpio_in = '1;                            // Rising edge on every pin
        wait_meip(1'b1, 10);
        pend = `SOC_IRQ_TOTAL'(mask) << SOC_IRQ_GPIO0;
        do
        begin
            e = lowest_id(pend);
            apb_read(addr_of(PSLV_IRQCTRL, 2), r);
            check_irq_id(irq_id_t'(r.prdata), e, "gpio claim");
            pend[e] = 1'b0;
        end
        while (e != '0);
        check_level(meip, 1'b0, "o_meip after last claim");
        apb_read(addr_of(PSLV_IRQCTRL, 0), r);
        check_data(r.prdata, '0, "pending bits after claims");
        apb_write(addr_of(PSLV_GPIO, 3), '0, r);
    endtask

    task automatic test_pnp();
        apb_out_type r;

        apb_read(addr_of(PSLV_PNP, 0), r);
        check_data(r.prdata, `SOC_HW_ID, "hardware id");
        apb_read(addr_of(PSLV_PNP, 1), r);
        check_data(r.prdata, `SOC_PSLV_TOTAL, "slot count");
        for (int s = 0; s < `SOC_PSLV_TOTAL; s++)
        begin
            apb_read(addr_of(PSLV_PNP, 4 + s), r);
            check_data(r.prdata, exp_desc(s), "slot descriptor");
        end
        apb_write(addr_of(PSLV_IRQCTRL, 1), 32'(1) << SOC_IRQ_PNP, r);
        apb_write(addr_of(PSLV_PNP, 2), 32'h1, r);
        apb_read(addr_of(PSLV_PNP, 2), r);
        check_data(r.prdata, 32'h1, "software interrupt bit");
        wait_meip(1'b1, 10);
        apb_read(addr_of(PSLV_IRQCTRL, 2), r);
        check_irq_id(irq_id_t'(r.prdata), SOC_IRQ_PNP, "software claim");
        apb_write(addr_of(PSLV_PNP, 2), '0, r);
        apb_read(addr_of(PSLV_IRQCTRL, 2), r);   // Relatched while the level was high
        check_irq_id(irq_id_t'(r.prdata), SOC_IRQ_PNP, "software claim after clear");
        apb_read(addr_of(PSLV_IRQCTRL, 2), r);
        check_irq_id(irq_id_t'(r.prdata), '0, "empty claim");
        check_level(meip, 1'b0, "o_meip after software claims");
    endtask

    initial
    begin
        apbi = '0;
        gpio_in = '0;
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #10;
        check_level(meip, 1'b0, "o_meip after reset");
        check_level(mtip, 1'b0, "o_mtip after reset");
        check_gpio(gpio_out, '0, "o_gpio after reset");
        check_gpio(gpio_dir, '0, "o_gpio_dir after reset");
        check_resp(apbo, '0, "idle bus after reset");
        finish_test("reset");
        test_gpio();
        finish_test("gpio");
        test_decode();
        finish_test("decode");
        test_timer();
        finish_test("timer");
        test_irq();
        finish_test("irq");
        test_pnp();
        finish_test("pnp");
        $display("summary: %0d tests, %0d transfers, %0d checks, %0d errors",
                 n_tests, n_xfers, n_checks, n_errors);
        if (n_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    // Watchdog sized from the transfer budget
    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with %0d transfers done", WATCHDOG_NS, n_xfers);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule: periph_soc_tb

// ==== tb/periph_soc_assert.sv ====
// Concurrent APB protocol and reset assertions, bound into periph_soc by the bind below
`include "soc_cfg_macros.svh"
`timescale 1ns/1ps

module periph_soc_assert
    import types_apb_pkg::*;
(
    input logic i_sys_clk,
    input logic i_rst_n,
    input apb_in_type i_apbi,
    input apb_out_type o_apbo,
    input logic o_meip,
    input logic [`SOC_GPIO_WIDTH-1:0] o_gpio_dir,
    input apb_in_vector apbi                    // Decoder fan-out to the slots
);

    logic [`SOC_PSLV_TOTAL-1:0] w_psel;

    always_comb
    begin
        for (int i = 0; i < `SOC_PSLV_TOTAL; i++)
            w_psel[i] = apbi[i].psel;
    end

    a_pready_in_access: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
        o_apbo.pready |-> (i_apbi.psel && i_apbi.penable))
        else $error("pready outside an access cycle");

    a_pslverr_with_pready: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
        o_apbo.pslverr |-> o_apbo.pready)
        else $error("pslverr without pready");

    // First cycle out of reset
    a_reset_quiet: assert property (@(posedge i_sys_clk)
        $rose(i_rst_n) |-> (!o_meip && (o_gpio_dir == '0)))
        else $error("o_meip or o_gpio_dir high right after reset");

    a_one_slot: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
        $onehot0(w_psel))
        else $error("more than one slot selected");

endmodule: periph_soc_assert

bind periph_soc periph_soc_assert u_periph_soc_assert (
    .i_sys_clk(i_sys_clk),
    .i_rst_n(i_rst_n),
    .i_apbi(i_apbi),
    .o_apbo(o_apbo),
    .o_meip(o_meip),
    .o_gpio_dir(o_gpio_dir),
    .apbi(apbi)
);

// ==== rtl/periph_soc.sv ====
// Peripheral subsystem top: APB decoder, GPIO, timer, interrupt controller and descriptor block
`include "soc_cfg_macros.svh"
`timescale 1ns/1ps

module periph_soc
    import types_apb_pkg::*;
    import types_soc_pkg::*;
(
    input logic i_sys_clk,                      // System/bus clock
    input logic i_rst_n,
    input apb_in_type i_apbi,                   // External APB master
    output apb_out_type o_apbo,
    input logic [`SOC_GPIO_WIDTH-1:0] i_gpio,
    output logic [`SOC_GPIO_WIDTH-1:0] o_gpio,
    output logic [`SOC_GPIO_WIDTH-1:0] o_gpio_dir,
    output logic o_mtip,                        // Machine timer interrupt
    output logic o_meip                         // Machine external interrupt
);

    apb_in_vector apbi;
    apb_out_vector apbo;
    logic [`SOC_GPIO_WIDTH-1:0] wb_irq_gpio;
    logic w_irq_pnp;
    logic [`SOC_IRQ_TOTAL-1:0] wb_ext_irqs;

    apb_bus1 bus1 (
        .i_clk(i_sys_clk),
        .i_rst_n(i_rst_n),
        .i_apbi(i_apbi),
        .o_apbo(o_apbo),
        .o_apbi(apbi),
        .i_apbo(apbo)
    );

    apb_gpio gpio0 (
        .i_clk(i_sys_clk),
        .i_rst_n(i_rst_n),
        .i_apbi(apbi[PSLV_GPIO]),
        .o_apbo(apbo[PSLV_GPIO]),
        .i_gpio(i_gpio),
        .o_gpio(o_gpio),
        .o_gpio_dir(o_gpio_dir),
        .o_irq(wb_irq_gpio)
    );

    apb_timer timer0 (
        .i_clk(i_sys_clk),
        .i_rst_n(i_rst_n),
        .i_apbi(apbi[PSLV_TIMER]),
        .o_apbo(apbo[PSLV_TIMER]),
        .o_mtip(o_mtip)
    );

    apb_irqctrl irqctrl0 (
        .i_clk(i_sys_clk),
        .i_rst_n(i_rst_n),
        .i_apbi(apbi[PSLV_IRQCTRL]),
        .o_apbo(apbo[PSLV_IRQCTRL]),
        .i_irq_request(wb_ext_irqs),
        .o_meip(o_meip)
    );

    apb_pnp pnp0 (
        .i_clk(i_sys_clk),
        .i_rst_n(i_rst_n),
        .i_apbi(apbi[PSLV_PNP]),
        .o_apbo(apbo[PSLV_PNP]),
        .o_irq(w_irq_pnp)
    );

    // Interrupt source map of the controller
    always_comb
    begin: comb_proc
        logic [`SOC_IRQ_TOTAL-1:0] vb_ext_irqs;

        vb_ext_irqs = '0;
        vb_ext_irqs[0] = 1'b0;                  // Id 0 means no interrupt
        vb_ext_irqs[SOC_IRQ_GPIO0 +: `SOC_GPIO_WIDTH] = wb_irq_gpio;
        vb_ext_irqs[SOC_IRQ_PNP] = w_irq_pnp;
        vb_ext_irqs[`SOC_IRQ_TOTAL-1:SOC_IRQ_PNP+1] = '0;
        wb_ext_irqs = vb_ext_irqs;
    end: comb_proc

endmodule: periph_soc

// ==== rtl/apb_pnp.sv ====
// Descriptor slave: hardware id, slot count, per-slot map entries and a software interrupt bit
`include "soc_cfg_macros.svh"
`timescale 1ns/1ps

module apb_pnp
    import types_apb_pkg::*;
    import types_soc_pkg::*;
(
    input logic i_clk,
    input logic i_rst_n,
    input apb_in_type i_apbi,
    output apb_out_type o_apbo,
    output logic o_irq
);

    logic r_swirq;
    logic [9:0] w_reg;
    dev_config_type w_desc;

    assign w_reg = i_apbi.paddr[`SOC_APB_REG_MSB:`SOC_APB_REG_LSB];
    assign w_desc = soc_map[w_reg[1:0]];     // Offsets 4..7 select slot 0..3

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_swirq <= 1'b0;
        end
        else if (i_apbi.psel && i_apbi.penable && i_apbi.pwrite && (w_reg == 10'd2))
        begin
            r_swirq <= i_apbi.pwdata[0];
        end
    end

    always_comb
    begin: read_proc
        o_apbo = '0;
        o_apbo.pready = i_apbi.psel & i_apbi.penable;
        case (w_reg)
        10'd0: o_apbo.prdata = `SOC_HW_ID;
        10'd1: o_apbo.prdata = apb_data_t'(`SOC_PSLV_TOTAL);
        10'd2: o_apbo.prdata = apb_data_t'(r_swirq);
        10'd4, 10'd5, 10'd6, 10'd7:
            o_apbo.prdata = {w_desc.dev_id, 12'h000, w_desc.page};
        default: o_apbo.prdata = '0;
        endcase
    end: read_proc

    assign o_irq = r_swirq;

endmodule: apb_pnp

// ==== rtl/apb_irqctrl.sv ====
// Reduced PLIC-style slave: latched pending bits, enable mask and a claim register
`include "soc_cfg_macros.svh"
`timescale 1ns/1ps

module apb_irqctrl
    import types_apb_pkg::*;
    import types_soc_pkg::*;
(
    input logic i_clk,
    input logic i_rst_n,
    input apb_in_type i_apbi,
    output apb_out_type o_apbo,
    input logic [`SOC_IRQ_TOTAL-1:0] i_irq_request,
    output logic o_meip
);

    logic [`SOC_IRQ_TOTAL-1:0] r_pending;
    logic [`SOC_IRQ_TOTAL-1:0] r_enable;
    logic r_meip;
    logic [`SOC_IRQ_TOTAL-1:0] w_active;
    irq_id_t w_claim_id;
    logic [`SOC_IRQ_TOTAL-1:0] w_claim_mask;
    logic w_access;
    logic [9:0] w_reg;

    assign w_access = i_apbi.psel & i_apbi.penable;
    assign w_reg = i_apbi.paddr[`SOC_APB_REG_MSB:`SOC_APB_REG_LSB];

    // Id 0 never counts as a source
    assign w_active = r_pending & r_enable & ~`SOC_IRQ_TOTAL'(1);

    // Lowest-numbered active id wins
    always_comb
    begin: claim_proc
        irq_id_t v_id;

        v_id = '0;
        for (int i = `SOC_IRQ_TOTAL-1; i >= 1; i--)
        begin
            if (w_active[i])
            begin
                v_id = irq_id_t'(i);
            end
        end
        w_claim_id = v_id;
    end: claim_proc

    always_comb
    begin: clear_proc
        w_claim_mask = '0;
        if (w_access && !i_apbi.pwrite && (w_reg == 10'd2))
        begin
            w_claim_mask[w_claim_id] = (w_claim_id != '0);   // Claim read clears its bit
        end
    end: clear_proc

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_pending <= '0;
            r_enable <= '0;
            r_meip <= 1'b0;
        end
        else
        begin
            r_pending <= (r_pending & ~w_claim_mask) | i_irq_request;
            r_meip <= |w_active;
            if (w_access && i_apbi.pwrite && (w_reg == 10'd1))
            begin
                r_enable <= i_apbi.pwdata[`SOC_IRQ_TOTAL-1:0];
            end
        end
    end

    always_comb
    begin: read_proc
        o_apbo = '0;
        o_apbo.pready = w_access;
        case (w_reg)
        10'd0: o_apbo.prdata = apb_data_t'(r_pending);
        10'd1: o_apbo.prdata = apb_data_t'(r_enable);
        10'd2: o_apbo.prdata = apb_data_t'(w_claim_id);
        default: o_apbo.prdata = '0;
        endcase
    end: read_proc

    assign o_meip = r_meip;

endmodule: apb_irqctrl

// ==== rtl/apb_timer.sv ====
// Machine timer slave: free-running 64-bit mtime, mtimecmp and a registered timer interrupt level
`timescale 1ns/1ps

module apb_timer
    import types_apb_pkg::*;
(
    input logic i_clk,
    input logic i_rst_n,
    input apb_in_type i_apbi,
    output apb_out_type o_apbo,
    output logic o_mtip
);

    logic [63:0] r_mtime;
    logic [63:0] r_mtimecmp;
    logic r_mtip;
    logic w_wr;
    logic [9:0] w_reg;

    assign w_wr = i_apbi.psel & i_apbi.penable & i_apbi.pwrite;
    assign w_reg = i_apbi.paddr[11:2];

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_mtime <= '0;
            r_mtimecmp <= '1;                   // Quiet until software programs it
            r_mtip <= 1'b0;
        end
        else
        begin
            r_mtime <= r_mtime + 64'd1;
            r_mtip <= (r_mtime >= r_mtimecmp);
            if (w_wr && (w_reg == 10'd2))
            begin
                r_mtimecmp[31:0] <= i_apbi.pwdata;
            end
            if (w_wr && (w_reg == 10'd3))
            begin
                r_mtimecmp[63:32] <= i_apbi.pwdata;
            end
        end
    end

    always_comb
    begin: read_proc
        o_apbo = '0;
        o_apbo.pready = i_apbi.psel & i_apbi.penable;
        case (w_reg)
        10'd0: o_apbo.prdata = r_mtime[31:0];
        10'd1: o_apbo.prdata = r_mtime[63:32];
        10'd2: o_apbo.prdata = r_mtimecmp[31:0];
        10'd3: o_apbo.prdata = r_mtimecmp[63:32];
        default: o_apbo.prdata = '0;
        endcase
    end: read_proc

    assign o_mtip = r_mtip;

endmodule: apb_timer

// ==== rtl/apb_gpio.sv ====
// GPIO slave: synchronized inputs, output and direction registers, rising-edge interrupt per pin
`include "soc_cfg_macros.svh"
`timescale 1ns/1ps

module apb_gpio
    import types_apb_pkg::*;
(
    input logic i_clk,
    input logic i_rst_n,
    input apb_in_type i_apbi,
    output apb_out_type o_apbo,
    input logic [`SOC_GPIO_WIDTH-1:0] i_gpio,
    output logic [`SOC_GPIO_WIDTH-1:0] o_gpio,
    output logic [`SOC_GPIO_WIDTH-1:0] o_gpio_dir,   // 1 = output
    output logic [`SOC_GPIO_WIDTH-1:0] o_irq         // One-cycle pulse per edge
);

    logic [`SOC_GPIO_WIDTH-1:0] r_sync1;
    logic [`SOC_GPIO_WIDTH-1:0] r_input;             // Second synchronizer stage
    logic [`SOC_GPIO_WIDTH-1:0] r_input_d;
    logic [`SOC_GPIO_WIDTH-1:0] r_output;
    logic [`SOC_GPIO_WIDTH-1:0] r_dir;
    logic [`SOC_GPIO_WIDTH-1:0] r_ie;
    logic [`SOC_GPIO_WIDTH-1:0] r_irq;
    logic w_wr;

    assign w_wr = i_apbi.psel & i_apbi.penable & i_apbi.pwrite;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_sync1 <= '0;
            r_input <= '0;
            r_input_d <= '0;
            r_output <= '0;
            r_dir <= '0;
            r_ie <= '0;
            r_irq <= '0;
        end
        else
        begin
            r_sync1 <= i_gpio;
            r_input <= r_sync1;
            r_input_d <= r_input;
            r_irq <= r_input & ~r_input_d & r_ie;    // Enabled rising edges only
            if (w_wr)
            begin
                case (i_apbi.paddr[`SOC_APB_REG_MSB:`SOC_APB_REG_LSB])
                10'd1: r_output <= i_apbi.pwdata[`SOC_GPIO_WIDTH-1:0];
                10'd2: r_dir <= i_apbi.pwdata[`SOC_GPIO_WIDTH-1:0];
                10'd3: r_ie <= i_apbi.pwdata[`SOC_GPIO_WIDTH-1:0];
                default: ;                           // Input register is read-only
                endcase
            end
        end
    end

    always_comb
    begin: read_proc
        o_apbo = '0;
        o_apbo.pready = i_apbi.psel & i_apbi.penable;
        case (i_apbi.paddr[`SOC_APB_REG_MSB:`SOC_APB_REG_LSB])
        10'd0: o_apbo.prdata = apb_data_t'(r_input);
        10'd1: o_apbo.prdata = apb_data_t'(r_output);
        10'd2: o_apbo.prdata = apb_data_t'(r_dir);
        10'd3: o_apbo.prdata = apb_data_t'(r_ie);
        default: o_apbo.prdata = '0;
        endcase
    end: read_proc

    assign o_gpio = r_output;
    assign o_gpio_dir = r_dir;
    assign o_irq = r_irq;

endmodule: apb_gpio

// ==== rtl/apb_bus1.sv ====
// APB decoder: routes the single master port to the slave slots and errors on unmapped addresses
`include "soc_cfg_macros.svh"
`timescale 1ns/1ps

module apb_bus1
    import types_apb_pkg::*;
    import types_soc_pkg::*;
(
    input logic i_clk,
    input logic i_rst_n,
    input apb_in_type i_apbi,           // From the external master
    output apb_out_type o_apbo,         // Back to the external master
    output apb_in_vector o_apbi,        // Fan-out to the slots
    input apb_out_vector i_apbo         // Slot responses
);

    logic w_hit;
    pslv_idx_e w_idx;
    logic r_err;                        // Unmapped transfer seen in setup

    // Page decode against the shared map
    always_comb
    begin: decode_proc
        logic v_hit;
        pslv_idx_e v_idx;

        v_hit = 1'b0;
        v_idx = PSLV_GPIO;
        for (int i = 0; i < `SOC_PSLV_TOTAL; i++)
        begin
            if ((i_apbi.paddr[31:16] == 16'h0000) &&
                (i_apbi.paddr[`SOC_APB_PAGE_MSB:`SOC_APB_PAGE_LSB] == soc_map[i].page))
            begin
                v_hit = 1'b1;
                v_idx = pslv_idx_e'(i);
            end
        end
        w_hit = v_hit;
        w_idx = v_idx;
    end: decode_proc

    // Only the decoded slot sees psel
    always_comb
    begin: fanout_proc
        for (int i = 0; i < `SOC_PSLV_TOTAL; i++)
        begin
            o_apbi[i] = i_apbi;
            o_apbi[i].psel = i_apbi.psel & w_hit & (w_idx == pslv_idx_e'(i));
        end
    end: fanout_proc

    always_comb
    begin: resp_proc
        o_apbo = '0;
        if (r_err)
        begin
            o_apbo.pready = 1'b1;       // Local error answer, prdata stays zero
            o_apbo.pslverr = 1'b1;
        end
        else if (w_hit)
        begin
            o_apbo = i_apbo[w_idx];
        end
    end: resp_proc

    // Flag raised at the end of setup so the error lands in the access cycle
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_err <= 1'b0;
        end
        else
        begin
            r_err <= i_apbi.psel & ~i_apbi.penable & ~w_hit;
        end
    end

endmodule: apb_bus1

// ==== rtl/types_soc_pkg.sv ====
// Slot indices, address map, device descriptors and interrupt ids shared across the subsystem
`include "soc_cfg_macros.svh"

package types_soc_pkg;

    // APB slave slot numbering
    typedef enum logic [1:0] {
        PSLV_GPIO    = 2'd0,
        PSLV_TIMER   = 2'd1,
        PSLV_IRQCTRL = 2'd2,
        PSLV_PNP     = 2'd3
    } pslv_idx_e;

    // Descriptor of one slot; page is address bits 15..12
    typedef struct packed {
        logic [15:0] dev_id;
        logic [3:0] page;
    } dev_config_type;

    typedef dev_config_type [`SOC_PSLV_TOTAL-1:0] dev_config_vector;

    // Address map, one page per slot in slot order
    localparam dev_config_vector soc_map = {
        dev_config_type'{dev_id: 16'h0504, page: 4'h3},   // PNP
        dev_config_type'{dev_id: 16'h0503, page: 4'h2},   // IRQCTRL
        dev_config_type'{dev_id: 16'h0502, page: 4'h1},   // TIMER
        dev_config_type'{dev_id: 16'h0501, page: 4'h0}    // GPIO
    };

    typedef logic [`SOC_IRQ_ID_WIDTH-1:0] irq_id_t;

    // GPIO pin n raises id SOC_IRQ_GPIO0 + n
    localparam irq_id_t SOC_IRQ_GPIO0 = 4'd1;
    localparam irq_id_t SOC_IRQ_PNP = 4'd13;

endpackage: types_soc_pkg

// ==== rtl/types_apb_pkg.sv ====
// APB transfer and response structs plus slot vectors, imported by the decoder, slaves and testbench
`include "soc_cfg_macros.svh"

package types_apb_pkg;

    // Register data as seen on the bus
    typedef logic [31:0] apb_data_t;

    // Master to slave
    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        logic [31:0] paddr;
        apb_data_t pwdata;
    } apb_in_type;

    // Slave to master
    typedef struct packed {
        logic pready;
        logic pslverr;
        apb_data_t prdata;
    } apb_out_type;

    // One entry per slave slot, index 0 in the low bits
    typedef apb_in_type [`SOC_PSLV_TOTAL-1:0] apb_in_vector;
    typedef apb_out_type [`SOC_PSLV_TOTAL-1:0] apb_out_vector;

endpackage: types_apb_pkg

// ==== rtl/soc_cfg_macros.svh ====
// Global sizes and identifiers of the peripheral subsystem, included by the packages and RTL
`ifndef SOC_CFG_MACROS_SVH
`define SOC_CFG_MACROS_SVH

// Number of GPIO pins on the single GPIO block
`define SOC_GPIO_WIDTH 12

// APB slave slots behind the decoder
`define SOC_PSLV_TOTAL 4

// Interrupt sources including id 0, which means no interrupt
`define SOC_IRQ_TOTAL 16

// Bits needed to hold one interrupt source id
`define SOC_IRQ_ID_WIDTH 4

// Hardware identifier reported by the descriptor block
`define SOC_HW_ID 32'hB41F_0C01

// Address bit ranges of the APB map
`define SOC_APB_PAGE_MSB 15
`define SOC_APB_PAGE_LSB 12
`define SOC_APB_REG_MSB 11
`define SOC_APB_REG_LSB 2

`endif
